/* Bender.yml */
package:
  name: user_req

sources:
  - files:
      - logic/req_pkg.sv
      - logic/net_pkg.sv
      - logic/meta_reg.sv
      - logic/req_credit_ctr.sv
      - logic/user_req_mux.sv
      - logic/user_req_top.sv
  - target: test
    files:
      - testbench/user_req_tb.sv

/* logic/meta_reg.sv */
// two-entry slice with a registered s_ready; m_data is undefined while m_valid is low.
`timescale 1ns/1ps
`default_nettype none

module meta_reg #(
  parameter int unsigned data_bits = 8
) (
  input  wire                  aclk,
  input  wire                  rst_n,
  input  wire                  s_valid,
  output logic                 s_ready,
  input  wire  [data_bits-1:0] s_data,
  output logic                 m_valid,
  input  wire                  m_ready,
  output logic [data_bits-1:0] m_data
);

  // main entry drives the output side.
  logic                 main_valid_q;
  logic [data_bits-1:0] main_data_q;
  // spare entry catches a transfer while main is stalled.
  logic                 skid_valid_q;
  logic [data_bits-1:0] skid_data_q;
  logic                 s_fire;
  logic                 main_free;

  assign s_fire    = s_valid & s_ready;
  // main can take new data this cycle.
  assign main_free = ~main_valid_q | m_ready;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      main_valid_q <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (main_free) begin
      // spare drains before new input, keeps order.
      main_valid_q <= skid_valid_q | s_fire;
      skid_valid_q <= 1'b0;
    end else if (s_fire) begin
      skid_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (main_free) begin
      main_data_q <= skid_valid_q ? skid_data_q : s_data;
    end
    // park input in the spare.
    if (!main_free && s_fire) begin
      skid_data_q <= s_data;
    end
  end

  // ready straight from a flop, low only with both entries full.
  assign s_ready = ~skid_valid_q;
  assign m_valid = main_valid_q;
  assign m_data  = main_data_q;

  // a stalled output keeps its valid and payload.
  stall_hold: assert property (@(posedge aclk) disable iff (!rst_n)
    m_valid && !m_ready |=> m_valid && $stable(m_data));

endmodule

`default_nettype wire

/* logic/net_pkg.sv */
// remote descriptors pair a read slot and a write slot; the credit limit applies per direction.
`default_nettype none

package net_pkg;

  import req_pkg::*;

  // read travels in req_1, write in req_2.
  typedef struct packed {
    req_t req_1;
    req_t req_2;
  } dreq_t;

  // outstanding remote requests allowed per direction.
  localparam int unsigned remote_credits = 4;
  // counter must hold the full limit.
  localparam int unsigned credit_bits = $clog2(remote_credits + 1);

  // card and host streams stay on the local path.
  function automatic logic is_strm_local(strm_t strm);
    return (strm == strm_card) || (strm == strm_host);
  endfunction

endpackage

`default_nettype wire

/* logic/req_credit_ctr.sv */
// done pulses must match earlier issues one to one; the count saturates at net_pkg::remote_credits.
`timescale 1ns/1ps
`default_nettype none

module req_credit_ctr (
  input  wire  aclk,
  input  wire  rst_n,
  input  wire  issue,
  input  wire  done,
  output logic credit_ok
);

  import net_pkg::*;

  // requests in flight on the remote side.
  logic [credit_bits-1:0] count_q;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      count_q <= '0;
    end else begin
      case ({issue, done})
        // new remote request.
        2'b10: count_q <= count_q + credit_bits'(1);
        // one request retired.
        2'b01: count_q <= count_q - credit_bits'(1);
        // both or neither, count holds.
        default: count_q <= count_q;
      endcase
    end
  end

  // combinational from the count.
  assign credit_ok = (count_q < credit_bits'(remote_credits));

  // no completion without an outstanding request.
  done_has_req: assert property (@(posedge aclk) disable iff (!rst_n)
    done |-> count_q != '0);

  // mux must hold remote issue at the limit.
  issue_has_credit: assert property (@(posedge aclk) disable iff (!rst_n)
    issue |-> credit_ok);

endmodule

`default_nettype wire

/* logic/req_pkg.sv */
// descriptor widths are fixed at build time and must match the shell side of the region.
`default_nettype none

package req_pkg;

  // virtual address width.
  localparam int unsigned vaddr_bits = 32;
  // byte length of one request.
  localparam int unsigned len_bits = 16;
  // virtual function id width.
  localparam int unsigned vfid_bits = 4;
  // destination queue index width.
  localparam int unsigned dest_bits = 4;

  // stream code carried in every request.
  typedef logic [1:0] strm_t;

  // on-card memory.
  localparam strm_t strm_card = 2'd0;
  // host memory over the bus.
  localparam strm_t strm_host = 2'd1;
  // remote peer over rdma.
  localparam strm_t strm_rdma = 2'd2;
  // remote peer over tcp.
  localparam strm_t strm_tcp = 2'd3;

  // request descriptor, msb first.
  typedef struct packed {
    logic [vaddr_bits-1:0] vaddr;
    logic [len_bits-1:0]   len;
    strm_t                 strm;
    logic [dest_bits-1:0]  dest;
    // owner region, set by the shell.
    logic [vfid_bits-1:0]  vfid;
    // request came from an active user region.
    logic                  actv;
    // request came from the host side.
    logic                  host;
    // last request of a transfer.
    logic                  last;
  } req_t;

endpackage

`default_nettype wire

/* logic/user_req_mux.sv */
// rd and wr are routed independently; a credit-blocked remote request also holds local traffic behind it.
`timescale 1ns/1ps
`default_nettype none

module user_req_mux #(
  parameter logic [req_pkg::vfid_bits-1:0] id_reg = '0
) (
  input  wire             aclk,
  input  wire             rst_n,
  input  wire             sq_rd_valid,
  output logic            sq_rd_ready,
  input  wire             req_pkg::req_t sq_rd_data,
  input  wire             sq_wr_valid,
  output logic            sq_wr_ready,
  input  wire             req_pkg::req_t sq_wr_data,
  output logic            local_rd_valid,
  input  wire             local_rd_ready,
  output req_pkg::req_t   local_rd_data,
  output logic            local_wr_valid,
  input  wire             local_wr_ready,
  output req_pkg::req_t   local_wr_data,
  output logic            remote_rd_valid,
  input  wire             remote_rd_ready,
  output net_pkg::dreq_t  remote_rd_data,
  output logic            remote_wr_valid,
  input  wire             remote_wr_ready,
  output net_pkg::dreq_t  remote_wr_data,
  input  wire             rd_credit_ok,
  input  wire             wr_credit_ok,
  output logic            rd_issue,
  output logic            wr_issue
);

  import req_pkg::*;
  import net_pkg::*;

  // requests after the ownership override.
  req_t  sq_rd_or;
  req_t  sq_wr_or;
  // registered requests at the router.
  logic  rd_int_valid;
  logic  rd_int_ready;
  req_t  rd_int_data;
  logic  wr_int_valid;
  logic  wr_int_ready;
  req_t  wr_int_data;
  // stream decode of the head request.
  logic  rd_is_remote;
  logic  wr_is_remote;
  // inputs of the output slices.
  logic  local_rd_in_valid;
  logic  local_rd_in_ready;
  logic  local_wr_in_valid;
  logic  local_wr_in_ready;
  logic  remote_rd_in_valid;
  logic  remote_rd_in_ready;
  dreq_t remote_rd_in_data;
  logic  remote_wr_in_valid;
  logic  remote_wr_in_ready;
  dreq_t remote_wr_in_data;

  // region owns every request it issues.
  always_comb begin
    sq_rd_or      = sq_rd_data;
    sq_rd_or.actv = 1'b1;
    sq_rd_or.host = 1'b0;
    sq_rd_or.vfid = id_reg;
    sq_wr_or      = sq_wr_data;
    sq_wr_or.actv = 1'b1;
    sq_wr_or.host = 1'b0;
    sq_wr_or.vfid = id_reg;
  end

  meta_reg #(.data_bits($bits(req_t))) u_sq_rd_reg (
    .aclk(aclk), .rst_n(rst_n),
    .s_valid(sq_rd_valid), .s_ready(sq_rd_ready), .s_data(sq_rd_or),
    .m_valid(rd_int_valid), .m_ready(rd_int_ready), .m_data(rd_int_data)
  );

  meta_reg #(.data_bits($bits(req_t))) u_sq_wr_reg (
    .aclk(aclk), .rst_n(rst_n),
    .s_valid(sq_wr_valid), .s_ready(sq_wr_ready), .s_data(sq_wr_or),
    .m_valid(wr_int_valid), .m_ready(wr_int_ready), .m_data(wr_int_data)
  );

  assign rd_is_remote = ~is_strm_local(rd_int_data.strm);
  assign wr_is_remote = ~is_strm_local(wr_int_data.strm);

  // remote side is closed while out of credits.
  assign local_rd_in_valid  = rd_int_valid & ~rd_is_remote;
  assign remote_rd_in_valid = rd_int_valid & rd_is_remote & rd_credit_ok;
  assign rd_int_ready = rd_is_remote ? (remote_rd_in_ready & rd_credit_ok) : local_rd_in_ready;
  assign local_wr_in_valid  = wr_int_valid & ~wr_is_remote;
  assign remote_wr_in_valid = wr_int_valid & wr_is_remote & wr_credit_ok;
  assign wr_int_ready = wr_is_remote ? (remote_wr_in_ready & wr_credit_ok) : local_wr_in_ready;

  // accepted remote handshake takes one credit.
  assign rd_issue = remote_rd_in_valid & remote_rd_in_ready;
  assign wr_issue = remote_wr_in_valid & remote_wr_in_ready;

  // read in slot one, write in slot two.
  always_comb begin
    remote_rd_in_data       = '0;
    remote_rd_in_data.req_1 = rd_int_data;
    remote_wr_in_data       = '0;
    remote_wr_in_data.req_2 = wr_int_data;
  end

  meta_reg #(.data_bits($bits(req_t))) u_local_rd_reg (
    .aclk(aclk), .rst_n(rst_n),
    .s_valid(local_rd_in_valid), .s_ready(local_rd_in_ready), .s_data(rd_int_data),
    .m_valid(local_rd_valid), .m_ready(local_rd_ready), .m_data(local_rd_data)
  );

  meta_reg #(.data_bits($bits(req_t))) u_local_wr_reg (
    .aclk(aclk), .rst_n(rst_n),
    .s_valid(local_wr_in_valid), .s_ready(local_wr_in_ready), .s_data(wr_int_data),
    .m_valid(local_wr_valid), .m_ready(local_wr_ready), .m_data(local_wr_data)
  );

  meta_reg #(.data_bits($bits(dreq_t))) u_remote_rd_reg (
    .aclk(aclk), .rst_n(rst_n),
    .s_valid(remote_rd_in_valid), .s_ready(remote_rd_in_ready), .s_data(remote_rd_in_data),
    .m_valid(remote_rd_valid), .m_ready(remote_rd_ready), .m_data(remote_rd_data)
  );

  meta_reg #(.data_bits($bits(dreq_t))) u_remote_wr_reg (
    .aclk(aclk), .rst_n(rst_n),
    .s_valid(remote_wr_in_valid), .s_ready(remote_wr_in_ready), .s_data(remote_wr_in_data),
    .m_valid(remote_wr_valid), .m_ready(remote_wr_ready), .m_data(remote_wr_data)
  );

  // each output only carries its own route and slot.
  rd_route_ok: assert property (@(posedge aclk) disable iff (!rst_n)
    (!local_rd_valid || is_strm_local(local_rd_data.strm)) && (!remote_rd_valid
      || (!is_strm_local(remote_rd_data.req_1.strm) && remote_rd_data.req_2 == '0)));
  wr_route_ok: assert property (@(posedge aclk) disable iff (!rst_n)
    (!local_wr_valid || is_strm_local(local_wr_data.strm)) && (!remote_wr_valid
      || (!is_strm_local(remote_wr_data.req_2.strm) && remote_wr_data.req_1 == '0)));

endmodule

`default_nettype wire

/* logic/user_req_top.sv */
// remote done pulses are one cycle wide, one per retired request, and must never exceed issues.
`timescale 1ns/1ps
`default_nettype none

module user_req_top #(
  parameter logic [req_pkg::vfid_bits-1:0] id_reg = '0
) (
  input  wire             aclk,
  input  wire             rst_n,
  input  wire             sq_rd_valid,
  output logic            sq_rd_ready,
  input  wire             req_pkg::req_t sq_rd_data,
  input  wire             sq_wr_valid,
  output logic            sq_wr_ready,
  input  wire             req_pkg::req_t sq_wr_data,
  output logic            local_rd_valid,
  input  wire             local_rd_ready,
  output req_pkg::req_t   local_rd_data,
  output logic            local_wr_valid,
  input  wire             local_wr_ready,
  output req_pkg::req_t   local_wr_data,
  output logic            remote_rd_valid,
  input  wire             remote_rd_ready,
  output net_pkg::dreq_t  remote_rd_data,
  output logic            remote_wr_valid,
  input  wire             remote_wr_ready,
  output net_pkg::dreq_t  remote_wr_data,
  input  wire             remote_rd_done,
  input  wire             remote_wr_done
);

  // credit state per direction.
  logic rd_credit_ok;
  logic wr_credit_ok;
  // remote requests entering the output slices.
  logic rd_issue;
  logic wr_issue;

  user_req_mux #(.id_reg(id_reg)) u_mux (
    .aclk(aclk), .rst_n(rst_n),
    .sq_rd_valid(sq_rd_valid), .sq_rd_ready(sq_rd_ready), .sq_rd_data(sq_rd_data),
    .sq_wr_valid(sq_wr_valid), .sq_wr_ready(sq_wr_ready), .sq_wr_data(sq_wr_data),
    .local_rd_valid(local_rd_valid), .local_rd_ready(local_rd_ready),
    .local_rd_data(local_rd_data),
    .local_wr_valid(local_wr_valid), .local_wr_ready(local_wr_ready),
    .local_wr_data(local_wr_data),
    .remote_rd_valid(remote_rd_valid), .remote_rd_ready(remote_rd_ready),
    .remote_rd_data(remote_rd_data),
    .remote_wr_valid(remote_wr_valid), .remote_wr_ready(remote_wr_ready),
    .remote_wr_data(remote_wr_data),
    .rd_credit_ok(rd_credit_ok), .wr_credit_ok(wr_credit_ok),
    .rd_issue(rd_issue), .wr_issue(wr_issue)
  );

  // read side counter.
  req_credit_ctr u_rd_credit (
    .aclk(aclk), .rst_n(rst_n),
    .issue(rd_issue), .done(remote_rd_done),
    .credit_ok(rd_credit_ok)
  );

  // write side counter.
  req_credit_ctr u_wr_credit (
    .aclk(aclk), .rst_n(rst_n),
    .issue(wr_issue), .done(remote_wr_done),
    .credit_ok(wr_credit_ok)
  );

endmodule

`default_nettype wire

/* testbench/user_req_tb.sv */
// expects region id 4'ha on the dut; done pulses only follow delivered remote requests.
`timescale 1ns/1ps
`default_nettype none

module user_req_tb;

  import req_pkg::*;
  import net_pkg::*;

  localparam logic [vfid_bits-1:0] region_id = 4'ha;
  localparam int timeout_cycles = 2000;
  localparam int settle_cycles = 12;

  // expected output channel and descriptor.
  typedef struct packed {
    logic [1:0] ch;
    dreq_t      d;
  } exp_t;

  logic  aclk, rst_n;
  logic  sq_rd_valid, sq_rd_ready, sq_wr_valid, sq_wr_ready;
  req_t  sq_rd_data, sq_wr_data, local_rd_data, local_wr_data;
  logic  local_rd_valid, local_rd_ready, local_wr_valid, local_wr_ready;
  logic  remote_rd_valid, remote_rd_ready, remote_wr_valid, remote_wr_ready;
  dreq_t remote_rd_data, remote_wr_data;
  logic  remote_rd_done, remote_wr_done;

  // channel 0 local_rd, 1 local_wr, 2 remote_rd, 3 remote_wr.
  string names[4] = '{"local_rd", "local_wr", "remote_rd", "remote_wr"};
  dreq_t exp_q[4][$];
  int    due_q[2][$];
  int    delivered[4];
  int    last_xfer[4];
  logic  held_v[4];
  dreq_t held_d[4];
  int    cyc, last_acc, errors, checks, tests, fails;
  logic  ready_all, done_auto;

  user_req_top #(.id_reg(region_id)) dut (.*);

  always #4 aclk = ~aclk;

  always @(posedge aclk) cyc <= cyc + 1;

  // sink readies are random unless forced.
  always @(posedge aclk) begin
    #1;
    local_rd_ready  = ready_all | ($urandom % 3 != 0);
    local_wr_ready  = ready_all | ($urandom % 3 != 0);
    remote_rd_ready = ready_all | ($urandom % 3 != 0);
    remote_wr_ready = ready_all | ($urandom % 3 != 0);
  end

  // at most one completion pulse per direction and cycle.
  always @(posedge aclk) begin
    #1;
    remote_rd_done = 1'b0;
    remote_wr_done = 1'b0;
    if (due_q[0].size() > 0 && due_q[0][0] <= cyc) begin
      void'(due_q[0].pop_front());
      remote_rd_done = 1'b1;
    end
    if (due_q[1].size() > 0 && due_q[1][0] <= cyc) begin
      void'(due_q[1].pop_front());
      remote_wr_done = 1'b1;
    end
  end

  task automatic check(input string name, input logic [121:0] exp_v, input logic [121:0] act_v);
    checks++;
    if (exp_v !== act_v) begin
      $display("[FAIL] %0s expected %0h got %0h", name, exp_v, act_v);
      errors++;
    end
  endtask

  // override the ownership fields, then pick channel and slot.
  function automatic exp_t expect_req(input req_t r, input logic wr);
    exp_t e;
    req_t o;
    o = r;
    o.actv = 1'b1;
    o.host = 1'b0;
    o.vfid = region_id;
    e.d = '0;
    if (r.strm == strm_card || r.strm == strm_host) begin
      e.ch = wr ? 2'd1 : 2'd0;
      e.d.req_2 = o;
    end else if (wr) begin
      e.ch = 2'd3;
      e.d.req_2 = o;
    end else begin
      e.ch = 2'd2;
      e.d.req_1 = o;
    end
    return e;
  endfunction

  function automatic req_t rand_req();
    logic [63:0] raw;
    raw = {$urandom(), $urandom()};
    return raw[$bits(req_t)-1:0];
  endfunction

  // called and returns at posedge plus 1 ns.
  task automatic send(input logic wr, input req_t r);
    exp_t e;
    int   t;
    e = expect_req(r, wr);
    if (wr) begin
      sq_wr_valid = 1'b1;
      sq_wr_data  = r;
    end else begin
      sq_rd_valid = 1'b1;
      sq_rd_data  = r;
    end
    t = 0;
    // registered ready has settled by now.
    while (!(wr ? sq_wr_ready : sq_rd_ready) && t < timeout_cycles) begin
      @(posedge aclk);
      #1;
      t++;
    end
    if (t >= timeout_cycles) begin
      $display("timeout: request on sq_%0s was never accepted", wr ? "wr" : "rd");
      errors++;
    end else begin
      exp_q[e.ch].push_back(e.d);
    end
    @(posedge aclk);
    #1;
    last_acc = cyc;
    if (wr) sq_wr_valid = 1'b0;
    else sq_rd_valid = 1'b0;
  endtask

  // compare, order and stall stability for one output channel.
  task automatic watch(input int ch, input logic v, input logic r, input dreq_t d);
    dreq_t e;
    if (held_v[ch]) begin
      check({names[ch], "_valid"}, 1, v);
      check({names[ch], "_data"}, held_d[ch], d);
    end
    held_v[ch] = v && !r;
    held_d[ch] = d;
    if (v && r) begin
      if (exp_q[ch].size() == 0) begin
        $display("unexpected transfer on %0s", names[ch]);
        errors++;
      end else begin
        e = exp_q[ch].pop_front();
        check({names[ch], "_data"}, e, d);
      end
      delivered[ch]++;
      last_xfer[ch] = cyc + 1;
      if (ch >= 2 && done_auto) due_q[ch-2].push_back(cyc + 2 + $urandom % 6);
    end
  endtask

  always @(negedge aclk) begin
    if (rst_n) begin
      watch(0, local_rd_valid, local_rd_ready, {req_t'(0), local_rd_data});
      watch(1, local_wr_valid, local_wr_ready, {req_t'(0), local_wr_data});
      watch(2, remote_rd_valid, remote_rd_ready, remote_rd_data);
      watch(3, remote_wr_valid, remote_wr_ready, remote_wr_data);
    end
  end

  task automatic wait_delivered(input int ch, input int n);
    int t;
    t = 0;
    while (delivered[ch] < n && t < timeout_cycles) begin
      @(posedge aclk);
      #1;
      t++;
    end
    if (delivered[ch] < n) begin
      $display("timeout: %0s delivered %0d of %0d requests", names[ch], delivered[ch], n);
      errors++;
    end
  endtask

  // all expected outputs seen and all completions returned.
  task automatic wait_drain();
    int t;
    t = 0;
    while ((exp_q[0].size() + exp_q[1].size() + exp_q[2].size() + exp_q[3].size()
            + due_q[0].size() + due_q[1].size()) != 0 && t < timeout_cycles) begin
      @(posedge aclk);
      #1;
      t++;
    end
    if (t >= timeout_cycles) begin
      $display("timeout: outputs or completions still pending after %0d cycles", t);
      errors++;
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    tests++;
    if (errors != err_before) fails++;
    $display("test %0s: %0s", name, (errors == err_before) ? "ok" : "errors found");
  endtask

  // limit plus two requests leaves one parked behind the limit.
  task automatic credit_test(input logic wr);
    int   ch;
    int   base;
    req_t r;
    ch = wr ? 3 : 2;
    done_auto = 1'b0;
    base = delivered[ch];
    for (int i = 0; i < remote_credits + 2; i++) begin
      r = rand_req();
      r.strm = (i % 2) ? strm_tcp : strm_rdma;
      send(wr, r);
    end
    wait_delivered(ch, base + remote_credits);
    repeat (settle_cycles) @(posedge aclk);
    #1;
    check({names[ch], "_count"}, remote_credits, delivered[ch] - base);
    due_q[ch-2].push_back(cyc + 1);
    wait_delivered(ch, base + remote_credits + 1);
    repeat (settle_cycles) @(posedge aclk);
    #1;
    check({names[ch], "_count"}, remote_credits + 1, delivered[ch] - base);
    // retire the rest and let the parked one get its own pulse.
    done_auto = 1'b1;
    repeat (remote_credits) due_q[ch-2].push_back(cyc + 1);
    wait_drain();
  endtask

  initial begin
    int   e0;
    int   base;
    req_t r;
    void'($urandom(47423));
    aclk = 1'b0;
    rst_n = 1'b0;
    sq_rd_valid = 1'b0;
    sq_wr_valid = 1'b0;
    sq_rd_data = '0;
    sq_wr_data = '0;
    {local_rd_ready, local_wr_ready, remote_rd_ready, remote_wr_ready} = '1;
    {remote_rd_done, remote_wr_done} = '0;
    ready_all = 1'b1;
    done_auto = 1'b1;
    {cyc, last_acc, errors, checks, tests, fails} = '0;

    // reset state inside reset and just after release.
    e0 = errors;
    repeat (2) @(posedge aclk);
    for (int k = 0; k < 2; k++) begin
      @(negedge aclk);
      check("valids", 0, {local_rd_valid, local_wr_valid, remote_rd_valid, remote_wr_valid});
      check("readies", 2'b11, {sq_rd_ready, sq_wr_ready});
      if (k == 0) begin
        @(posedge aclk);
        #1;
        rst_n = 1'b1;
      end
    end
    @(posedge aclk);
    #1;
    end_test("reset_state", e0);

    // one local read through both slices.
    e0 = errors;
    base = delivered[0];
    r = rand_req();
    r.strm = strm_card;
    send(1'b0, r);
    wait_delivered(0, base + 1);
    check("local_rd_latency", 2, last_xfer[0] - last_acc);
    wait_drain();
    end_test("override_latency", e0);

    // every stream code in both directions.
    e0 = errors;
    fork
      for (int i = 0; i < 40; i++) begin
        r = rand_req();
        r.strm = strm_t'(i % 4);
        send(1'b0, r);
      end
      for (int i = 0; i < 40; i++) send(1'b1, rand_req());
    join
    wait_drain();
    end_test("routing", e0);

    // random sink readies and idle gaps.
    e0 = errors;
    ready_all = 1'b0;
    fork
      for (int i = 0; i < 60; i++) begin
        send(1'b0, rand_req());
        if ($urandom % 4 == 0) begin
          @(posedge aclk);
          #1;
        end
      end
      for (int i = 0; i < 60; i++) begin
        send(1'b1, rand_req());
        if ($urandom % 4 == 0) begin
          @(posedge aclk);
          #1;
        end
      end
    join
    wait_drain();
    ready_all = 1'b1;
    end_test("back_pressure", e0);

    e0 = errors;
    credit_test(1'b0);
    credit_test(1'b1);
    end_test("credits", e0);

    $display("%0d tests run, %0d failed, %0d checks, %0d errors", tests, fails, checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* user_req_top.f */
logic/req_pkg.sv
logic/net_pkg.sv
logic/meta_reg.sv
logic/req_credit_ctr.sv
logic/user_req_mux.sv
logic/user_req_top.sv
testbench/user_req_tb.sv
